// File: Makefile
TOP = tb_cholesky
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: source/chol_div.sv
`timescale 1ns/1ps

module chol_div #(
    parameter int ITERATIONS = chol_pkg::DIV_CYCLES
) (
    input  logic    clk,
    input  logic    rst,
    chol_op_if.unit op
);
    import chol_pkg::*;

    localparam int NUM_W = DATA_W + FRAC_W;    // Dividend is |a| << FRAC_W
    localparam int CNT_W = $clog2(ITERATIONS + 1);

    logic [CNT_W-1:0]            cnt;
    logic                        fix;          // Sign step pending
    logic                        neg;
    logic [DATA_W-1:0]           a_mag;
    logic [DATA_W-1:0]           b_mag;
    logic [NUM_W+ITERATIONS-1:0] num_ext;
    logic [ITERATIONS-1:0]       quo;          // Dividend bits out, quotient bits in
    logic [DATA_W-1:0]           dvs;
    logic [DATA_W-1:0]           rem;
    logic [DATA_W:0]             rem_shift;
    logic [DATA_W:0]             diff;
    logic [ITERATIONS+NUM_W-1:0] quo_scaled;
    logic [DATA_W-1:0]           quo_mag;
    logic                        ge;

    // Work on magnitudes, sign goes back at the end
    assign a_mag   = op.a[DATA_W-1] ? -op.a : op.a;
    assign b_mag   = op.b[DATA_W-1] ? -op.b : op.b;
    assign num_ext = {a_mag, {FRAC_W{1'b0}}, {ITERATIONS{1'b0}}};

    assign rem_shift  = {rem, quo[ITERATIONS-1]};
    assign diff       = rem_shift - {1'b0, dvs};
    assign ge         = ~diff[DATA_W];             // No borrow
    assign quo_scaled = {quo, {NUM_W{1'b0}}} >> ITERATIONS;
    assign quo_mag    = DATA_W'(quo_scaled);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            fix     <= 1'b0;
            op.done <= 1'b0;
        end else begin
            op.done <= fix;
            fix     <= cnt == CNT_W'(1);
            if (op.start) begin
                cnt <= CNT_W'(ITERATIONS);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.start) begin
            quo <= num_ext[NUM_W+ITERATIONS-1 -: ITERATIONS];
            dvs <= b_mag;
            rem <= '0;
            neg <= op.a[DATA_W-1] ^ op.b[DATA_W-1];
        end else if (cnt != '0) begin
            quo <= {quo[ITERATIONS-2:0], ge};
            rem <= ge ? diff[DATA_W-1:0] : rem_shift[DATA_W-1:0];
        end
        if (fix) begin
            op.result <= neg ? -quo_mag : quo_mag;    // Truncates toward zero
        end
    end

endmodule

// File: source/chol_mac.sv
`timescale 1ns/1ps

module chol_mac (
    input  logic     clk,
    input  logic     rst,
    chol_mac_if.unit mac
);
    import chol_pkg::*;

    acc_t seed;
    acc_t prod;

    // A element widened to Q32.32 range before the shift
    assign seed = mac.c;

    // Full 64-bit signed product of two Q16.16 values
    assign prod = mac.a * mac.b;

    // Forms A(i,j) minus the running sum of L(i,k) * L(j,k)
    always_ff @(posedge clk) begin
        if (rst) begin
            mac.acc <= '0;
        end else if (mac.load) begin
            mac.acc <= seed <<< FRAC_W;
        end else if (mac.en) begin
            mac.acc <= mac.acc - prod;
        end
    end

endmodule

// File: source/chol_mac_if.sv
`timescale 1ns/1ps

interface chol_mac_if;
    import chol_pkg::*;

    logic  load;    // Seed acc with c << FRAC_W
    logic  en;      // Subtract a * b from acc
    data_t a;
    data_t b;
    data_t c;
    acc_t  acc;

    modport ctrl (
        output load, en, a, b, c,
        input  acc
    );

    modport unit (
        input  load, en, a, b, c,
        output acc
    );

endinterface

// File: source/chol_op_if.sv
`timescale 1ns/1ps

interface chol_op_if #(
    parameter int WIDTH = chol_pkg::DATA_W
);

    logic                    start;     // One-cycle pulse, operands valid
    logic signed [WIDTH-1:0] a;
    logic signed [WIDTH-1:0] b;         // Unused by the root
    logic signed [WIDTH-1:0] result;    // Held until the next start
    logic                    done;      // One-cycle pulse

    modport ctrl (
        output start, a, b,
        input  result, done
    );

    modport unit (
        input  start, a, b,
        output result, done
    );

endinterface

// File: source/chol_pkg.sv
package chol_pkg;

    // Fixed-point format
    localparam int DATA_W = 32;
    localparam int FRAC_W = 16;    // Q16.16 elements
    localparam int ACC_W  = 64;    // Q32.32 products and sums

    // Matrix geometry
    localparam int N        = 5;
    localparam int NUM_ELEM = N * (N + 1) / 2;
    localparam int MAT_W    = NUM_ELEM * DATA_W;

    // Iteration counts of the serial units
    localparam int SQRT_CYCLES = 24;    // One root bit per cycle
    localparam int DIV_CYCLES  = 48;    // One quotient bit per cycle

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Packed slot of element (row, col), zero based, row >= col
    // Slots run row by row: (0,0) (1,0) (1,1) (2,0) ...
    // Slot k sits at bits DATA_W*k and up
    function automatic int elem_index(input int row, input int col);
        return row * (row + 1) / 2 + col;
    endfunction

endpackage

// File: source/chol_sequencer.sv
`timescale 1ns/1ps

module chol_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [chol_pkg::MAT_W-1:0] a,
    input  logic                       a_valid,
    output logic [chol_pkg::MAT_W-1:0] l,
    output logic                       l_valid,
    chol_op_if.ctrl                    sq,
    chol_op_if.ctrl                    dv,
    chol_mac_if.ctrl                   mac
);
    import chol_pkg::*;

    localparam int IDX_W = $clog2(N);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_ACCUMULATE,
        S_REDUCE,
        S_WAIT_UNIT,
        S_FINISH
    } state_t;

    state_t           state;
    logic [MAT_W-1:0] a_reg;
    logic [IDX_W-1:0] i;            // Row
    logic [IDX_W-1:0] j;            // Column
    logic [IDX_W-1:0] k;            // Inner product index
    logic             diag;
    int               idx_ij;
    int               idx_ik;
    int               idx_jk;
    int               idx_jj;
    data_t            l_jj;
    data_t            reduced;
    data_t            unit_result;
    logic             unit_done;

    // ----------------------------
    // Element addressing
    // ----------------------------
    assign idx_ij = elem_index(i, j);
    assign idx_ik = elem_index(i, k);
    assign idx_jk = elem_index(j, k);
    assign idx_jj = elem_index(j, j);

    assign diag    = i == j;
    assign l_jj    = l[idx_jj*DATA_W +: DATA_W];
    assign reduced = mac.acc[FRAC_W+DATA_W-1:FRAC_W];    // Q32.32 back to Q16.16

    // ----------------------------
    // Accumulator control
    // ----------------------------
    assign mac.load = state == S_LOAD;
    assign mac.en   = state == S_ACCUMULATE;
    assign mac.c    = a_reg[idx_ij*DATA_W +: DATA_W];    // Seed with A(i,j)
    assign mac.a    = l[idx_ik*DATA_W +: DATA_W];
    assign mac.b    = l[idx_jk*DATA_W +: DATA_W];

    // ----------------------------
    // Root and divider control
    // ----------------------------

    // Diagonal goes to the root, the rest of the column is divided by L(j,j)
    assign sq.start = state == S_REDUCE && diag;
    assign sq.a     = reduced;
    assign sq.b     = '0;
    assign dv.start = state == S_REDUCE && !diag;
    assign dv.a     = reduced;
    assign dv.b     = l_jj;

    assign unit_done   = diag ? sq.done : dv.done;
    assign unit_result = diag ? sq.result : dv.result;

    // ----------------------------
    // Column-by-column FSM
    // ----------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            i       <= '0;
            j       <= '0;
            k       <= '0;
            l       <= '0;
            l_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (a_valid) begin
                        l       <= '0;
                        l_valid <= 1'b0;
                        i       <= '0;
                        j       <= '0;
                        state   <= S_LOAD;
                    end
                end

                S_LOAD: begin
                    k <= '0;
                    // First column has nothing to subtract
                    state <= (j == '0) ? S_REDUCE : S_ACCUMULATE;
                end

                S_ACCUMULATE: begin
                    k <= k + 1'b1;
                    if (k == j - 1'b1) begin
                        state <= S_REDUCE;
                    end
                end

                S_REDUCE: begin
                    state <= S_WAIT_UNIT;    // Unit started this cycle
                end

                S_WAIT_UNIT: begin
                    if (unit_done) begin
                        l[idx_ij*DATA_W +: DATA_W] <= unit_result;
                        if (i == IDX_W'(N - 1)) begin
                            if (j == IDX_W'(N - 1)) begin
                                state <= S_FINISH;
                            end else begin
                                j     <= j + 1'b1;
                                i     <= j + 1'b1;    // Next diagonal
                                state <= S_LOAD;
                            end
                        end else begin
                            i     <= i + 1'b1;
                            state <= S_LOAD;
                        end
                    end
                end

                S_FINISH: begin
                    l_valid <= 1'b1;
                    state   <= S_IDLE;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Capture A on acceptance
    always_ff @(posedge clk) begin
        if (state == S_IDLE && a_valid) begin
            a_reg <= a;
        end
    end

endmodule

// File: source/chol_sqrt.sv
`timescale 1ns/1ps

module chol_sqrt #(
    parameter int ITERATIONS = chol_pkg::SQRT_CYCLES
) (
    input  logic    clk,
    input  logic    rst,
    chol_op_if.unit op
);
    import chol_pkg::*;

    localparam int RAD_W  = DATA_W + FRAC_W;    // Radicand is a << FRAC_W
    localparam int SQ_W   = 2 * ITERATIONS;     // Two radicand bits per root bit
    localparam int HALF_W = RAD_W / 2;          // Root width at full precision
    localparam int CNT_W  = $clog2(ITERATIONS + 1);

    logic [CNT_W-1:0]             cnt;
    logic [SQ_W-1:0]              rad;
    logic [ITERATIONS-1:0]        rem;
    logic [ITERATIONS-1:0]        root;
    logic [RAD_W+SQ_W-1:0]        rad_ext;
    logic [ITERATIONS+1:0]        rem_shift;
    logic [ITERATIONS+1:0]        trial;
    logic [ITERATIONS+1:0]        rem_nxt;
    logic [ITERATIONS-1:0]        root_nxt;
    logic [ITERATIONS+HALF_W-1:0] root_scaled;
    logic                         ge;

    // Negative radicand collapses to zero
    assign rad_ext = op.a[DATA_W-1] ? '0 : {op.a, {FRAC_W{1'b0}}, {SQ_W{1'b0}}};

    // Restoring step
    assign rem_shift   = {rem, rad[SQ_W-1 -: 2]};
    assign trial       = {root, 2'b01};
    assign ge          = rem_shift >= trial;
    assign rem_nxt     = ge ? rem_shift - trial : rem_shift;
    assign root_nxt    = {root[ITERATIONS-2:0], ge};
    assign root_scaled = {root_nxt, {HALF_W{1'b0}}} >> ITERATIONS;    // Back to Q16.16

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            op.done <= 1'b0;
        end else begin
            op.done <= cnt == CNT_W'(1);    // Last step this cycle
            if (op.start) begin
                cnt <= CNT_W'(ITERATIONS);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op.start) begin
            rad  <= rad_ext[RAD_W+SQ_W-1 -: SQ_W];    // MSB aligned
            rem  <= '0;
            root <= '0;
        end else if (cnt != '0) begin
            rad  <= rad << 2;
            rem  <= rem_nxt[ITERATIONS-1:0];
            root <= root_nxt;
            if (cnt == CNT_W'(1)) begin
                op.result <= DATA_W'(root_scaled);
            end
        end
    end

endmodule

// File: source/cholesky.sv
`timescale 1ns/1ps

module cholesky #(
    parameter int SQRT_ITER = chol_pkg::SQRT_CYCLES,
    parameter int DIV_ITER  = chol_pkg::DIV_CYCLES
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [chol_pkg::MAT_W-1:0] a,
    input  logic                       a_valid,
    output logic [chol_pkg::MAT_W-1:0] l,
    output logic                       l_valid
);
    import chol_pkg::*;

    chol_op_if #(.WIDTH(DATA_W)) sq_if ();     // Square root channel
    chol_op_if #(.WIDTH(DATA_W)) dv_if ();     // Shared divider channel
    chol_mac_if                  mac_if ();

    chol_sequencer i_sequencer (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid),
        .sq      (sq_if.ctrl),
        .dv      (dv_if.ctrl),
        .mac     (mac_if.ctrl)
    );

    chol_sqrt #(.ITERATIONS(SQRT_ITER)) i_sqrt (
        .clk (clk),
        .rst (rst),
        .op  (sq_if.unit)
    );

    chol_div #(.ITERATIONS(DIV_ITER)) i_div (
        .clk (clk),
        .rst (rst),
        .op  (dv_if.unit)
    );

    chol_mac i_mac (
        .clk (clk),
        .rst (rst),
        .mac (mac_if.unit)
    );

endmodule

// File: sources.f
source/chol_pkg.sv
source/chol_op_if.sv
source/chol_mac_if.sv
source/chol_sqrt.sv
source/chol_div.sv
source/chol_mac.sv
source/chol_sequencer.sv
source/cholesky.sv
test/tb_cholesky.sv

// File: test/tb_cholesky.sv
`timescale 1ns/1ps

module tb_cholesky;
    import chol_pkg::*;

    localparam int     SEED  = 30735;
    localparam longint LIMIT = 20 * NUM_ELEM * (DIV_CYCLES + SQRT_CYCLES + 16);

    logic             clk;
    logic             rst;
    logic [MAT_W-1:0] a;
    logic             a_valid;
    logic [MAT_W-1:0] l;
    logic             l_valid;

    int     a_q    [N][N];    // Q16.16 input in both triangles
    int     a_keep [N][N];
    int     l_exp  [N][N];    // Expected factor in the lower part
    int     error_count;
    int     check_count;
    int     test_count;
    int     errors_at_start;
    longint cycle_count;

    cholesky i_cholesky (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog over the whole run
    initial begin
        cycle_count = 0;
        while (cycle_count < LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout waiting for l_valid");
        $display("RESULT: FAIL");
        $finish;
    end

    // ------------------------------
    // Checking and reporting
    // ------------------------------
    task automatic check_value(input string what, input logic signed [63:0] got,
                               input logic signed [63:0] expected);
        check_count++;
        if (got !== expected) begin
            $display("Error: %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %s finished, %0d errors", name, error_count - errors_at_start);
    endtask

    task automatic check_result(input string name);
        data_t got;
        int    slot;
        slot = 0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c <= r; c++) begin
                got = data_t'(l[slot*DATA_W +: DATA_W]);
                check_value($sformatf("%s L(%0d,%0d)", name, r, c), got, l_exp[r][c]);
                slot++;
            end
        end
    endtask

    // ------------------------------
    // Matrices and reference model
    // ------------------------------
    task automatic clear_matrix();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                a_q[r][c]   = 0;
                l_exp[r][c] = 0;
            end
        end
    endtask

    // Value in quarters mirrored above the diagonal
    task automatic set_pair(input int r, input int c, input int quarters);
        a_q[r][c] = quarters <<< (FRAC_W - 2);
        a_q[c][r] = quarters <<< (FRAC_W - 2);
    endtask

    task automatic set_dense_matrix();
        clear_matrix();
        set_pair(0, 0, 40);
        set_pair(1, 1, 44);
        set_pair(2, 2, 48);
        set_pair(3, 3, 52);
        set_pair(4, 4, 56);
        set_pair(1, 0, -10);    // -2.5
        set_pair(2, 0, 3);
        set_pair(2, 1, 5);
        set_pair(3, 0, 8);
        set_pair(3, 1, -1);
        set_pair(3, 2, 6);
        set_pair(4, 0, 4);
        set_pair(4, 1, 7);
        set_pair(4, 2, -5);
        set_pair(4, 3, 2);
    endtask

    // M * M^T + 5I with entries of M from -3 to 3
    task automatic build_random_matrix();
        int m [N][N];
        int sum;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                m[r][c] = int'($urandom_range(6)) - 3;
            end
        end
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                sum = (r == c) ? 5 : 0;
                for (int t = 0; t < N; t++) begin
                    sum += m[r][t] * m[c][t];
                end
                a_q[r][c] = sum <<< FRAC_W;
            end
        end
    endtask

    function automatic logic [MAT_W-1:0] pack_lower();
        logic [MAT_W-1:0] word;
        int               slot;
        word = '0;
        slot = 0;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c <= r; c++) begin
                word[slot*DATA_W +: DATA_W] = a_q[r][c];
                slot++;
            end
        end
        return word;
    endfunction

    // Largest r with r*r <= v by bisection
    function automatic longint int_sqrt(input longint v);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 64'd16777216;
        while (hi - lo > 1) begin
            mid = (lo + hi) / 2;
            if (mid * mid <= v) begin
                lo = mid;
            end else begin
                hi = mid;
            end
        end
        return lo;
    endfunction

    task automatic compute_reference();
        longint acc;
        int     red;
        for (int j = 0; j < N; j++) begin
            for (int i = j; i < N; i++) begin
                acc = longint'(a_q[i][j]) <<< FRAC_W;
                for (int k = 0; k < j; k++) begin
                    acc = acc - longint'(l_exp[i][k]) * longint'(l_exp[j][k]);
                end
                red = int'(acc >>> FRAC_W);    // Bits 47 to 16
                if (i == j) begin
                    l_exp[i][j] = (red < 0) ? 0 : int'(int_sqrt(longint'(red) <<< FRAC_W));
                end else begin
                    l_exp[i][j] = int'((longint'(red) <<< FRAC_W) / longint'(l_exp[j][j]));
                end
            end
        end
    endtask

    // ------------------------------
    // Stimulus and tests
    // ------------------------------
    task automatic apply_matrix(input logic [MAT_W-1:0] value);
        a       = value;
        a_valid = 1'b1;
        @(posedge clk);
        #1;
        a_valid = 1'b0;
    endtask

    task automatic wait_result();
        while (!l_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_reset_state();
        begin_test();
        repeat (5) begin
            check_value("l_valid after reset", l_valid, 0);
            check_value("l nonzero after reset", |l, 0);
            @(posedge clk);
            #1;
        end
        end_test("reset state");
    endtask

    task automatic test_identity();
        begin_test();
        clear_matrix();
        for (int d = 0; d < N; d++) begin
            a_q[d][d]   = 1 <<< FRAC_W;
            l_exp[d][d] = 1 <<< FRAC_W;
        end
        apply_matrix(pack_lower());
        wait_result();
        check_result("identity");
        end_test("identity");
    endtask

    task automatic test_diagonal();
        begin_test();
        clear_matrix();
        for (int d = 0; d < N; d++) begin
            a_q[d][d]   = ((d + 2) * (d + 2)) <<< FRAC_W;
            l_exp[d][d] = (d + 2) <<< FRAC_W;    // Roots 2 to 6
        end
        apply_matrix(pack_lower());
        wait_result();
        check_result("diagonal");
        end_test("diagonal");
    endtask

    task automatic test_dense();
        begin_test();
        set_dense_matrix();
        compute_reference();
        apply_matrix(pack_lower());
        wait_result();
        check_result("dense");
        end_test("dense");
    endtask

    task automatic test_random();
        begin_test();
        for (int n = 0; n < 10; n++) begin
            build_random_matrix();
            compute_reference();
            apply_matrix(pack_lower());
            wait_result();
            check_result($sformatf("random %0d", n));
        end
        end_test("random");
    endtask

    task automatic test_busy_and_hold();
        logic [MAT_W-1:0] second;
        begin_test();
        build_random_matrix();
        a_keep = a_q;
        second = pack_lower();
        set_dense_matrix();
        compute_reference();
        apply_matrix(pack_lower());
        repeat (20) @(posedge clk);
        #1;
        apply_matrix(second);    // Busy so it is dropped
        check_value("l_valid while busy", l_valid, 0);
        wait_result();
        check_result("busy");
        repeat (10) @(posedge clk);
        #1;
        check_value("l_valid hold", l_valid, 1);
        check_result("hold");
        a_q = a_keep;
        compute_reference();
        apply_matrix(second);
        check_value("l_valid after accept", l_valid, 0);
        check_value("l nonzero after accept", |l, 0);
        wait_result();
        check_result("second");
        end_test("busy and hold");
    endtask

    initial begin
        void'($urandom(SEED));
        rst             = 1'b1;
        a               = '0;
        a_valid         = 1'b0;
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        errors_at_start = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_identity();
        test_diagonal();
        test_dense();
        test_random();
        test_busy_and_hold();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
